/* dv/elevator_display_sva.sv */
`timescale 1ns/1ns

module elevator_display_sva (
    input logic                             clk,
    input logic                             rst,
    input logic                             enable,
    input elevator_display_pkg::coord_t     x_coord,
    input elevator_display_pkg::coord_t     y_coord,
    input elevator_display_pkg::sim_state_t sim_state,
    input logic [7:0]                       destination,
    input logic [3:0]                       r,
    input logic [3:0]                       g,
    input logic [3:0]                       b
);
    import elevator_display_pkg::*;

    int   fail_count = 0;
    rgb_t pixel;

    assign pixel = {r, g, b};

    task automatic note_failure(input string rule);
        fail_count++;
        $error("FAIL at %0t ns: colour rule for %s broken", $time, rule);
    endtask

    function automatic logic shaft_rows(coord_t y);
        return (y >= TOP_MARGIN) && (y < SHAFT_BOTTOM);
    endfunction

    function automatic logic sky_at(coord_t x, coord_t y);
        return (x < SIDE_MARGIN) || (y < TOP_MARGIN) ||
               ((x >= SCREEN_W - SIDE_MARGIN) && (x < SCREEN_W) && (y < SHAFT_BOTTOM));
    endfunction

    function automatic logic building_at(coord_t x, coord_t y);
        return !sky_at(x, y) && ((x < LEFT_BUILDING_END) ||
               ((x >= RIGHT_BUILDING_START) && (x < SCREEN_W - SIDE_MARGIN)));
    endfunction

    function automatic logic outline_at(coord_t x, coord_t y);
        return shaft_rows(y) &&
               (((x >= MID_OUTLINE_START) && (x < RIGHT_SHAFT_START)) ||
                ((x >= RIGHT_OUTLINE_START) && (x < RIGHT_BUILDING_START)));
    endfunction

    function automatic logic shaft_at(coord_t x, coord_t y);
        return shaft_rows(y) &&
               (((x >= LEFT_BUILDING_END) && (x < MID_OUTLINE_START)) ||
                ((x >= RIGHT_SHAFT_START) && (x < RIGHT_OUTLINE_START)));
    endfunction

    // Ground floor band and odd bands are light
    function automatic rgb_t floor_shade(coord_t y);
        int band;
        band = (int'(y) - TOP_MARGIN) / FLOOR_HEIGHT;
        if (band >= 5) begin
            return COLOR_FLOOR_LIGHT;
        end
        return (band % 2 == 1) ? COLOR_FLOOR_LIGHT : COLOR_FLOOR_DARK;
    endfunction

    function automatic rgb_t idle_shade(coord_t y);
        return (int'(y) >= 395) ? COLOR_CAR : COLOR_SHAFT;
    endfunction

    // Car top rises half a floor per code step
    function automatic rgb_t moving_shade(coord_t x, coord_t y, logic [7:0] dest);
        int n;
        int top;
        n = (x < MID_OUTLINE_START) ? int'(dest[7:4]) : int'(dest[3:0]);
        if (n > 10) begin
            n = 10;
        end
        top = 390 - (75 * n) / 2;
        return (int'(y) >= top && int'(y) < top + 75) ? COLOR_CAR : COLOR_SHAFT;
    endfunction

    // Sign only shows over the right shaft
    function automatic rgb_t stop_shade(coord_t x, coord_t y);
        if ((x >= SIGN_X0) && (x < SIGN_X1) && (x >= RIGHT_SHAFT_START) &&
            (y >= SIGN_Y0) && (y < SIGN_Y1)) begin
            return COLOR_SIGN;
        end
        return COLOR_OUTLINE;
    endfunction

    a_reset_black: assert property (@(posedge clk) disable iff (rst)
        $past(rst, 1) || $past(rst, 2) |-> pixel == '0)
        else note_failure("reset");

    a_blank: assert property (@(posedge clk) disable iff (rst)
        !$past(enable, 2) |-> pixel == '0)
        else note_failure("blanking");

    a_sky: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) && !$past(rst, 1) && $past(enable, 2) &&
        sky_at($past(x_coord, 2), $past(y_coord, 2)) |-> pixel == COLOR_SKY)
        else note_failure("sky");

    a_building: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) && !$past(rst, 1) && $past(enable, 2) &&
        building_at($past(x_coord, 2), $past(y_coord, 2))
        |-> pixel == floor_shade($past(y_coord, 2)))
        else note_failure("building");

    a_outline: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) && !$past(rst, 1) && $past(enable, 2) &&
        outline_at($past(x_coord, 2), $past(y_coord, 2)) |-> pixel == COLOR_OUTLINE)
        else note_failure("outline");

    a_idle: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) && !$past(rst, 1) && $past(enable, 2) &&
        $past(sim_state, 2) == SIM_IDLE && shaft_at($past(x_coord, 2), $past(y_coord, 2))
        |-> pixel == idle_shade($past(y_coord, 2)))
        else note_failure("idle car");

    a_moving: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) && !$past(rst, 1) && $past(enable, 2) &&
        $past(sim_state, 2) == SIM_MOVING && shaft_at($past(x_coord, 2), $past(y_coord, 2))
        |-> pixel == moving_shade($past(x_coord, 2), $past(y_coord, 2),
                                  $past(destination, 2)))
        else note_failure("moving car");

    a_stop: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) && !$past(rst, 1) && $past(enable, 2) &&
        $past(sim_state, 2) >= 2'd2 && shaft_at($past(x_coord, 2), $past(y_coord, 2))
        |-> pixel == stop_shade($past(x_coord, 2), $past(y_coord, 2)))
        else note_failure("stop sign");

    a_grass: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 2) && !$past(rst, 1) && $past(enable, 2) &&
        !sky_at($past(x_coord, 2), $past(y_coord, 2)) &&
        !building_at($past(x_coord, 2), $past(y_coord, 2)) &&
        !outline_at($past(x_coord, 2), $past(y_coord, 2)) &&
        !shaft_at($past(x_coord, 2), $past(y_coord, 2)) |-> pixel == COLOR_GRASS)
        else note_failure("grass");

endmodule

bind elevator_display elevator_display_sva checker_u (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .x_coord     (x_coord),
    .y_coord     (y_coord),
    .sim_state   (sim_state),
    .destination (destination),
    .r           (r),
    .g           (g),
    .b           (b)
);

/* dv/elevator_display_tb.sv */
`timescale 1ns/1ns

module elevator_display_tb;
    import elevator_display_pkg::*;

    localparam int DRAIN_LIMIT = 20;

    logic       clk;
    logic       rst;
    logic       enable;
    coord_t     x_coord;
    coord_t     y_coord;
    sim_state_t sim_state;
    logic [7:0] destination;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    logic [31:0] rand_state;
    int          tests_passed;
    int          tests_failed;
    int          fails_at_start;
    string       test_name;

    elevator_display dut (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .x_coord     (x_coord),
        .y_coord     (y_coord),
        .sim_state   (sim_state),
        .destination (destination),
        .r           (r),
        .g           (g),
        .b           (b)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // LCG, upper half of the state is the usable part
    function automatic int random_below(int limit);
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return int'(rand_state[31:16]) % limit;
    endfunction

    task automatic drive_pixel(input logic en, input int x, input int y,
                               input int st, input logic [7:0] dest);
        @(posedge clk);
        #5;
        enable      = en;
        x_coord     = coord_t'(x);
        y_coord     = coord_t'(y);
        sim_state   = sim_state_t'(st);
        destination = dest;
    endtask

    task automatic drive_random(input logic en);
        drive_pixel(en, random_below(1024), random_below(512), random_below(4),
                    8'(random_below(256)));
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        fails_at_start = dut.checker_u.fail_count;
    endtask

    // Blank the input, then wait for three black outputs in a row
    task automatic finish_test();
        int streak;
        int waited;
        int fails;
        streak = 0;
        waited = 0;
        fails  = 0;
        drive_pixel(1'b0, 0, 0, 0, 8'h00);
        while (streak < 3 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #5;
            waited++;
            if ({r, g, b} == 12'h000) begin
                streak++;
            end else begin
                streak = 0;
            end
        end
        if (streak < 3) begin
            $display("Timeout in %s: output did not go black within %0d cycles of blanking",
                     test_name, DRAIN_LIMIT);
            fails++;
        end
        fails = fails + dut.checker_u.fail_count - fails_at_start;
        if (fails == 0) begin
            tests_passed++;
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL at %0t ns: %s had %0d failed checks", $time, test_name, fails);
        end
    endtask

    initial begin
        rand_state   = 32'h457;
        tests_passed = 0;
        tests_failed = 0;
        rst          = 1'b1;
        enable       = 1'b0;
        x_coord      = '0;
        y_coord      = '0;
        sim_state    = '0;
        destination  = '0;

        // Live pixels during reset must not leak out
        begin_test("reset_blanking");
        for (int i = 0; i < 4; i++) begin
            drive_random(1'b1);
        end
        rst = 1'b0;
        for (int i = 0; i < 32; i++) begin
            drive_random(1'b0);
        end
        finish_test();

        begin_test("static_scenery");
        for (int i = 0; i < 600; i++) begin
            drive_random(1'b1);
        end
        finish_test();

        begin_test("idle_cars");
        for (int i = 0; i < 400; i++) begin
            drive_pixel(1'b1, 210 + random_below(185), random_below(480), 0,
                        8'(random_below(256)));
        end
        finish_test();

        // Every nibble pair, one left and one right pixel per step
        begin_test("moving_cars");
        for (int left = 0; left < 16; left++) begin
            for (int right = 0; right < 16; right++) begin
                for (int k = 0; k < 3; k++) begin
                    drive_pixel(1'b1, 210 + random_below(85), random_below(480), 1,
                                8'(left * 16 + right));
                    drive_pixel(1'b1, 305 + random_below(90), random_below(480), 1,
                                8'(left * 16 + right));
                end
            end
        end
        finish_test();

        begin_test("stop_sign");
        for (int i = 0; i < 400; i++) begin
            drive_pixel(1'b1, 210 + random_below(185),
                        (i % 2 == 0) ? 190 + random_below(80) : random_below(480),
                        2 + random_below(2), 8'(random_below(256)));
        end
        finish_test();

        begin_test("throughput");
        for (int i = 0; i < 500; i++) begin
            drive_pixel(random_below(4) != 0, random_below(700), random_below(500),
                        random_below(4), 8'(random_below(256)));
        end
        finish_test();

        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/elevator_display_pkg.sv
source/pixel_if.sv
source/car_locator.sv
source/region_classifier.sv
source/shade_palette.sv
source/elevator_display.sv
dv/elevator_display_sva.sv
dv/elevator_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module elevator_display_tb \
    -f filelist.f -o elevator_display_sim > build.log 2>&1 &&
./obj_dir/elevator_display_sim +verilator+error+limit+100000 > sim.log 2>&1
grep -q "All tests passed" sim.log &&
    echo "Simulation passed, see sim.log" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* source/car_locator.sv */
`timescale 1ns/1ns

module car_locator (
    input  elevator_display_pkg::coord_t       y_coord,
    input  elevator_display_pkg::sim_state_t   sim_state,
    input  elevator_display_pkg::dest_nibble_t position,
    output logic                               in_car
);
    import elevator_display_pkg::*;

    // Car top when parked on the ground floor
    localparam int BASE_TOP = SHAFT_BOTTOM - FLOOR_HEIGHT;

    // Code 10 is the top floor, anything above stays there
    localparam dest_nibble_t MAX_POSITION = 4'd10;

    localparam coord_t IDLE_TOP = coord_t'(SHAFT_BOTTOM - CAR_HEIGHT_IDLE);

    dest_nibble_t pos_clipped;
    coord_t       car_top;
    coord_t       car_end;

    always_comb begin
        pos_clipped = (position > MAX_POSITION) ? MAX_POSITION : position;
        // One code step is half a floor, rounded down
        car_top = coord_t'(BASE_TOP - (FLOOR_HEIGHT * int'(pos_clipped)) / 2);
        car_end = car_top + coord_t'(FLOOR_HEIGHT);
    end

    always_comb begin
        case (sim_state)
            SIM_IDLE: begin
                in_car = (y_coord >= IDLE_TOP);
            end
            SIM_MOVING: begin
                in_car = (y_coord >= car_top) && (y_coord < car_end);
            end
            default: begin
                // Stop states hide the cars
                in_car = 1'b0;
            end
        endcase
    end

endmodule

/* source/elevator_display.sv */
`timescale 1ns/1ns

module elevator_display (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             enable,
    input  elevator_display_pkg::coord_t     x_coord,
    input  elevator_display_pkg::coord_t     y_coord,
    input  elevator_display_pkg::sim_state_t sim_state,
    input  logic [7:0]                       destination,
    output logic [3:0]                       r,
    output logic [3:0]                       g,
    output logic [3:0]                       b
);
    import elevator_display_pkg::*;

    rgb_t color;

    // Stage 1 to stage 2
    pixel_if pix ();

    region_classifier u_classifier (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .x_coord     (x_coord),
        .y_coord     (y_coord),
        .sim_state   (sim_state),
        .destination (destination),
        .pix         (pix.producer)
    );

    shade_palette u_palette (
        .clk   (clk),
        .rst   (rst),
        .pix   (pix.consumer),
        .color (color)
    );

    assign r = color.r;
    assign g = color.g;
    assign b = color.b;

endmodule

/* source/elevator_display_pkg.sv */
package elevator_display_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [3:0] dest_nibble_t;
    typedef logic [1:0] sim_state_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef enum logic [2:0] {
        REGION_SKY,
        REGION_BUILDING,
        REGION_OUTLINE,
        REGION_LSHAFT,
        REGION_RSHAFT,
        REGION_GRASS
    } region_t;

    // Stop states are 2 and 3, told apart by the upper bit
    localparam sim_state_t SIM_IDLE   = 2'd0;
    localparam sim_state_t SIM_MOVING = 2'd1;

    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    localparam int SIDE_MARGIN = 20;
    localparam int TOP_MARGIN  = 15;

    localparam int FLOOR_HEIGHT    = 75;
    localparam int CAR_HEIGHT_IDLE = 70;

    // Last shaft row is one above this
    localparam int SHAFT_BOTTOM = SCREEN_H - TOP_MARGIN;

    // Left building runs right up to the left shaft
    localparam int LEFT_BUILDING_END = 210;

    localparam int MID_OUTLINE_START    = 295;
    localparam int RIGHT_SHAFT_START    = 305;
    localparam int RIGHT_OUTLINE_START  = 395;
    localparam int RIGHT_BUILDING_START = 405;

    // Stop sign box, half open on both axes
    localparam int SIGN_X0 = 300;
    localparam int SIGN_X1 = 340;
    localparam int SIGN_Y0 = 200;
    localparam int SIGN_Y1 = 260;

    localparam rgb_t COLOR_SKY         = '{r: 4'd2,  g: 4'd15, b: 4'd8};
    localparam rgb_t COLOR_FLOOR_DARK  = '{r: 4'd9,  g: 4'd10, b: 4'd10};
    localparam rgb_t COLOR_FLOOR_LIGHT = '{r: 4'd11, g: 4'd11, b: 4'd11};
    localparam rgb_t COLOR_OUTLINE     = '{r: 4'd0,  g: 4'd0,  b: 4'd0};
    localparam rgb_t COLOR_SHAFT       = '{r: 4'd8,  g: 4'd4,  b: 4'd1};
    localparam rgb_t COLOR_CAR         = '{r: 4'd4,  g: 4'd4,  b: 4'd4};
    localparam rgb_t COLOR_SIGN        = '{r: 4'd15, g: 4'd0,  b: 4'd0};
    localparam rgb_t COLOR_GRASS       = '{r: 4'd0,  g: 4'd15, b: 4'd0};

endpackage

/* source/pixel_if.sv */
`timescale 1ns/1ns

interface pixel_if;
    import elevator_display_pkg::*;

    logic    active;
    region_t region;
    logic    floor_light;
    logic    car_hit;
    logic    stop_mode;
    logic    sign_hit;

    modport producer (
        output active,
        output region,
        output floor_light,
        output car_hit,
        output stop_mode,
        output sign_hit
    );

    modport consumer (
        input active,
        input region,
        input floor_light,
        input car_hit,
        input stop_mode,
        input sign_hit
    );

endinterface

/* source/region_classifier.sv */
`timescale 1ns/1ns

module region_classifier (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             enable,
    input  elevator_display_pkg::coord_t     x_coord,
    input  elevator_display_pkg::coord_t     y_coord,
    input  elevator_display_pkg::sim_state_t sim_state,
    input  logic [7:0]                       destination,
    pixel_if.producer                        pix
);
    import elevator_display_pkg::*;

    localparam int RIGHT_BUILDING_END = SCREEN_W - SIDE_MARGIN;
    localparam int TOP_FLOOR_BAND     = 5;

    region_t    region;
    logic [2:0] floor_band;
    logic       floor_light;
    logic       shaft_rows;
    logic       sign_hit;
    logic       left_in_car;
    logic       right_in_car;
    logic       car_hit;

    // Upper nibble drives the left car
    car_locator left_car (
        .y_coord   (y_coord),
        .sim_state (sim_state),
        .position  (destination[7:4]),
        .in_car    (left_in_car)
    );

    car_locator right_car (
        .y_coord   (y_coord),
        .sim_state (sim_state),
        .position  (destination[3:0]),
        .in_car    (right_in_car)
    );

    assign shaft_rows = (y_coord >= TOP_MARGIN) && (y_coord < SHAFT_BOTTOM);

    assign sign_hit = (x_coord >= SIGN_X0) && (x_coord < SIGN_X1) &&
                      (y_coord >= SIGN_Y0) && (y_coord < SIGN_Y1);

    // Priority decode, first match wins
    always_comb begin
        if ((x_coord < SIDE_MARGIN) || (y_coord < TOP_MARGIN) ||
            ((x_coord >= RIGHT_BUILDING_END) && (x_coord < SCREEN_W) &&
             (y_coord < SHAFT_BOTTOM))) begin
            region = REGION_SKY;
        end else if ((x_coord < LEFT_BUILDING_END) ||
                     ((x_coord >= RIGHT_BUILDING_START) &&
                      (x_coord < RIGHT_BUILDING_END))) begin
            region = REGION_BUILDING;
        end else if (shaft_rows &&
                     (((x_coord >= MID_OUTLINE_START) && (x_coord < RIGHT_SHAFT_START)) ||
                      ((x_coord >= RIGHT_OUTLINE_START) &&
                       (x_coord < RIGHT_BUILDING_START)))) begin
            region = REGION_OUTLINE;
        end else if (shaft_rows && (x_coord >= LEFT_BUILDING_END) &&
                     (x_coord < MID_OUTLINE_START)) begin
            region = REGION_LSHAFT;
        end else if (shaft_rows && (x_coord >= RIGHT_SHAFT_START) &&
                     (x_coord < RIGHT_OUTLINE_START)) begin
            region = REGION_RSHAFT;
        end else begin
            region = REGION_GRASS;
        end
    end

    // Floor band counts floor lines above the row, ground floor saturates
    always_comb begin
        floor_band = 3'd0;
        for (int k = 1; k <= TOP_FLOOR_BAND; k++) begin
            if (y_coord >= TOP_MARGIN + k * FLOOR_HEIGHT) begin
                floor_band = floor_band + 3'd1;
            end
        end
    end

    assign floor_light = floor_band[0] || (floor_band == 3'(TOP_FLOOR_BAND));

    always_comb begin
        case (region)
            REGION_LSHAFT: car_hit = left_in_car;
            REGION_RSHAFT: car_hit = right_in_car;
            default:       car_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pix.active      <= 1'b0;
            pix.region      <= REGION_SKY;
            pix.floor_light <= 1'b0;
            pix.car_hit     <= 1'b0;
            pix.stop_mode   <= 1'b0;
            pix.sign_hit    <= 1'b0;
        end else begin
            pix.active      <= enable;
            pix.region      <= region;
            pix.floor_light <= floor_light;
            pix.car_hit     <= car_hit;
            pix.stop_mode   <= sim_state[1];
            pix.sign_hit    <= sign_hit;
        end
    end

endmodule

/* source/shade_palette.sv */
`timescale 1ns/1ns

module shade_palette (
    input  logic                       clk,
    input  logic                       rst,
    pixel_if.consumer                  pix,
    output elevator_display_pkg::rgb_t color
);
    import elevator_display_pkg::*;

    rgb_t shaft_color;
    rgb_t next_color;

    // Shaft contents depend on the state group
    always_comb begin
        if (pix.stop_mode) begin
            shaft_color = pix.sign_hit ? COLOR_SIGN : COLOR_OUTLINE;
        end else if (pix.car_hit) begin
            shaft_color = COLOR_CAR;
        end else begin
            shaft_color = COLOR_SHAFT;
        end
    end

    always_comb begin
        case (pix.region)
            REGION_SKY: begin
                next_color = COLOR_SKY;
            end
            REGION_BUILDING: begin
                next_color = pix.floor_light ? COLOR_FLOOR_LIGHT : COLOR_FLOOR_DARK;
            end
            REGION_OUTLINE: begin
                next_color = COLOR_OUTLINE;
            end
            REGION_LSHAFT, REGION_RSHAFT: begin
                next_color = shaft_color;
            end
            default: begin
                next_color = COLOR_GRASS;
            end
        endcase

        // Blanking
        if (!pix.active) begin
            next_color = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            color <= '0;
        end else begin
            color <= next_color;
        end
    end

endmodule
